// File: verilog/ks10MemPkg.sv
package ks10MemPkg;

   ////////////////////////////////////////
   // Word and field types
   ////////////////////////////////////////

   // Bits numbered PDP-10 style, bit 0 is the MSB

   typedef logic [ 0:35] busWord_t;      // Bus address or data word
   typedef logic [16:35] memAddr_t;      // Physical memory address field
   typedef logic [18:35] ioAddr_t;       // IO register address field
   typedef logic [ 0: 3] devNum_t;       // Device number
   typedef logic [ 0: 4] hsbIndex_t;     // One of 32 HSB words

   // Implemented main memory, much smaller than a real KS-10
   localparam int memIndexWidth = 10;
   localparam int memWords      = 1024;  // 2**memIndexWidth

   typedef logic [0:memIndexWidth-1] memIndex_t;

   ////////////////////////////////////////
   // Address word flags
   ////////////////////////////////////////

   // Flags live in bits 0 to 13 of the address word
   localparam int flagRead   = 3;        // Read cycle
   localparam int flagWrTest = 4;        // Write test
   localparam int flagWrite  = 5;        // Write cycle
   localparam int flagPhys   = 8;        // Physical reference
   localparam int flagIo     = 10;       // IO space, not memory

   ////////////////////////////////////////
   // Field bounds
   ////////////////////////////////////////

   // Hi is the most significant bit, so the lower index

   localparam int devFieldHi     = 14;   // Device number
   localparam int devFieldLo     = 17;

   localparam int ioAddrFieldHi  = 18;   // IO address
   localparam int ioAddrFieldLo  = 35;

   localparam int memAddrFieldHi = 16;   // Memory address
   localparam int memAddrFieldLo = 35;

   ////////////////////////////////////////
   // Address constants
   ////////////////////////////////////////

   // Memory controller answers as device 0
   localparam devNum_t  memDevice = 4'd0;

   // MSR location in IO space
   localparam ioAddr_t  msrIoAddr = 18'o100000;

   // HSB window start, matched on bits 16 to 30
   localparam memAddr_t hsbBase   = 20'o0376000;

   // Memory status register
   // Error and power-fail flags writable, plus the ECC disable in bit 35
   localparam busWord_t msrWriteMask  = 36'o740000_000001;
   localparam busWord_t msrResetValue = 36'o004000_000000;  // Power-up flag set

endpackage

// File: verilog/memBusIf.sv
interface memBusIf;

   import ks10MemPkg::*;

   // Storage strobes
   logic      memRead;                   // Memory space read, main or HSB
   logic      memWrite;                  // Main memory write
   logic      hsbWrite;                  // HSB write
   logic      msrWrite;                  // Status register write

   // Word indexes and payload
   memIndex_t memIndex;
   hsbIndex_t hsbIndex;
   busWord_t  writeData;

   // Response side
   logic      selMem;                    // Read data from main memory
   logic      selHsb;                    // Read data from HSB
   logic      selMsr;                    // Read data from MSR
   logic      ackNext;                   // Acknowledge next cycle

   modport decode (output memRead, memWrite, hsbWrite, msrWrite, memIndex, hsbIndex,
                   writeData, selMem, selHsb, selMsr, ackNext);

   modport storage (input memRead, memWrite, hsbWrite, memIndex, hsbIndex, writeData);

   modport stat (input msrWrite, writeData);

   modport response (input selMem, selHsb, selMsr, ackNext);

endinterface

// File: verilog/memDecode.sv
module memDecode (
      input  logic                 busReq,    // Request strobe
      input  ks10MemPkg::busWord_t busAddr,   // Flags and address
      input  ks10MemPkg::busWord_t busData,   // Write data
      memBusIf.decode              bus
   );

   import ks10MemPkg::*;

   logic     rdFlag;
   logic     wtFlag;
   logic     wrFlag;
   logic     physFlag;
   logic     ioFlag;
   devNum_t  devNum;
   ioAddr_t  ioAddr;
   memAddr_t memAddr;

   logic     implHit;                         // Inside implemented memory
   logic     hsbHit;                          // Inside the HSB window
   logic     msrHit;                          // Our status register
   logic     memSpace;                        // Request to memory space
   logic     msrRead;
   logic     memWrReq;                        // Any memory space write
   logic     memWrTest;

   ////////////////////////////////////////
   // Split the address word
   ////////////////////////////////////////

   assign rdFlag   = busAddr[flagRead];
   assign wtFlag   = busAddr[flagWrTest];
   assign wrFlag   = busAddr[flagWrite];
   assign physFlag = busAddr[flagPhys];
   assign ioFlag   = busAddr[flagIo];
   assign devNum   = busAddr[devFieldHi:devFieldLo];
   assign ioAddr   = busAddr[ioAddrFieldHi:ioAddrFieldLo];
   assign memAddr  = busAddr[memAddrFieldHi:memAddrFieldLo];

   // Everything above the index must be zero
   assign implHit = (memAddr[memAddrFieldHi:memAddrFieldLo-memIndexWidth] == '0);

   // 32 word window, compare above the HSB index
   assign hsbHit = (memAddr[memAddrFieldHi:memAddrFieldLo-$bits(hsbIndex_t)] ==
                    hsbBase[memAddrFieldHi:memAddrFieldLo-$bits(hsbIndex_t)]);

   assign msrHit   = ioFlag & physFlag & (devNum == memDevice) & (ioAddr == msrIoAddr);
   assign memSpace = busReq & !ioFlag;

   ////////////////////////////////////////
   // Strobes and selects
   ////////////////////////////////////////

   assign msrRead      = busReq & rdFlag & msrHit;
   assign bus.msrWrite = busReq & wrFlag & msrHit;
   assign bus.memRead  = memSpace & rdFlag & (implHit | hsbHit);  // Else NXM, no ack
   assign memWrReq     = memSpace & wrFlag;                       // Acked even if NXM
   assign memWrTest    = memSpace & wtFlag;                       // Ack only

   assign bus.memWrite = memWrReq & implHit & !hsbHit;
   assign bus.hsbWrite = memWrReq & hsbHit;            // HSB shadows nothing below

   assign bus.memIndex  = memAddr[memAddrFieldLo-memIndexWidth+1:memAddrFieldLo];
   assign bus.hsbIndex  = memAddr[memAddrFieldLo-$bits(hsbIndex_t)+1:memAddrFieldLo];
   assign bus.writeData = busData;

   assign bus.selMem  = bus.memRead & implHit;
   assign bus.selHsb  = bus.memRead & hsbHit;
   assign bus.selMsr  = msrRead;                       // MSR write returns zero
   assign bus.ackNext = msrRead | bus.msrWrite | bus.memRead | memWrReq | memWrTest;

endmodule

// File: verilog/memStat.sv
module memStat (
      input  logic                 cpuClk,    // CPU clock
      input  logic                 reset,     // Synchronous reset
      memBusIf.stat                bus,
      output ks10MemPkg::busWord_t status     // Current MSR value
   );

   import ks10MemPkg::*;

   ////////////////////////////////////////
   // Memory status register
   ////////////////////////////////////////

   //
   // Only bits in the write mask follow the bus.
   // The rest hold their value, the power-up flag
   // stays set until the next reset.
   //

   always_ff @(posedge cpuClk)
   begin
      if (reset)
      begin
         status <= msrResetValue;             // Power-up state
      end
      else if (bus.msrWrite)
      begin
         // Masked merge of old value and bus data
         status <= (status & ~msrWriteMask) | (bus.writeData & msrWriteMask);
      end
   end

   // Read side is the register itself, no extra stage

endmodule

// File: verilog/memArray.sv
module memArray #(
      parameter int depth = 32                // Words in the store
   ) (
      input  logic                     cpuClk,     // CPU clock
      input  logic                     write,      // Write strobe
      input  logic [0:$clog2(depth)-1] index,      // Word index
      input  ks10MemPkg::busWord_t     writeData,  // Word to store
      output ks10MemPkg::busWord_t     readData    // Registered read word
   );

   import ks10MemPkg::*;

   ////////////////////////////////////////
   // Word store
   ////////////////////////////////////////

   busWord_t store [0:depth-1];

   //
   // Single port, one access per edge.
   // Read data is registered so it shows up
   // the cycle after the request.
   //

   always_ff @(posedge cpuClk)
   begin
      if (write)
      begin
         store[index] <= writeData;
         readData     <= writeData;           // Write-first
      end
      else
      begin
         readData <= store[index];            // Indexed read
      end
   end

   // Every edge reads the indexed word, the response
   // block decides if it goes onto the bus

endmodule

// File: verilog/memResponse.sv
module memResponse (
      input  logic                 cpuClk,      // CPU clock
      input  logic                 reset,       // Synchronous reset
      memBusIf.response            bus,
      input  ks10MemPkg::busWord_t memData,     // Main memory read word
      input  ks10MemPkg::busWord_t hsbData,     // HSB read word
      input  ks10MemPkg::busWord_t status,      // MSR contents
      output logic                 busAck,      // Acknowledge to master
      output ks10MemPkg::busWord_t busDataOut   // Read data to master
   );

   logic [0:2] srcSel;                        // One-hot, mem hsb msr

   ////////////////////////////////////////
   // Registered acknowledge and source
   ////////////////////////////////////////

   always_ff @(posedge cpuClk)
   begin
      if (reset)
      begin
         busAck <= 1'b0;
         srcSel <= '0;
      end
      else
      begin
         busAck <= bus.ackNext;               // Lines up with array read data
         srcSel <= {bus.selMem, bus.selHsb, bus.selMsr};
      end
   end

   // Read data mux, zero unless a read is acked
   always_comb
   begin
      case (srcSel)
         3'b100:  busDataOut = memData;
         3'b010:  busDataOut = hsbData;
         3'b001:  busDataOut = status;
         default: busDataOut = '0;            // Writes, tests and idle
      endcase
   end

endmodule

// File: verilog/ks10Mem.sv
module ks10Mem (
      input  logic                 cpuClk,      // CPU clock
      input  logic                 reset,       // Synchronous reset
      input  logic                 busReq,      // Request strobe
      input  ks10MemPkg::busWord_t busAddrIn,   // Flags and address
      input  ks10MemPkg::busWord_t busDataIn,   // Write data
      output logic                 busAck,      // Acknowledge
      output ks10MemPkg::busWord_t busDataOut   // Read data
   );

   import ks10MemPkg::*;

   memBusIf bus ();                           // Decoder to block signals

   busWord_t memData;                         // Main memory read word
   busWord_t hsbData;                         // HSB read word
   busWord_t msrData;                         // MSR contents

   ////////////////////////////////////////
   // Address decode
   ////////////////////////////////////////

   memDecode decoder (
      .busReq   (busReq),
      .busAddr  (busAddrIn),
      .busData  (busDataIn),
      .bus      (bus)
   );

   ////////////////////////////////////////
   // Targets
   ////////////////////////////////////////

   memStat msr (
      .cpuClk   (cpuClk),
      .reset    (reset),
      .bus      (bus),
      .status   (msrData)
   );

   // Main memory
   memArray #(.depth(memWords)) mainMem (
      .cpuClk    (cpuClk),
      .write     (bus.memWrite),
      .index     (bus.memIndex),
      .writeData (bus.writeData),
      .readData  (memData)
   );

   // Halt status block, 32 words
   memArray #(.depth(32)) hsbMem (
      .cpuClk    (cpuClk),
      .write     (bus.hsbWrite),
      .index     (bus.hsbIndex),
      .writeData (bus.writeData),
      .readData  (hsbData)
   );

   ////////////////////////////////////////
   // Response to the bus
   ////////////////////////////////////////

   memResponse responder (
      .cpuClk     (cpuClk),
      .reset      (reset),
      .bus        (bus),
      .memData    (memData),
      .hsbData    (hsbData),
      .status     (msrData),
      .busAck     (busAck),
      .busDataOut (busDataOut)
   );

endmodule

// File: bench/ks10MemTb.sv
module ks10MemTb;

   import ks10MemPkg::*;

   typedef struct {
      string    name;
      logic     req;
      busWord_t addr;
      busWord_t data;
      logic     expAck;
      busWord_t expData;
   } step_t;

   logic     cpuClk;
   logic     reset;
   logic     busReq;
   busWord_t busAddrIn;
   busWord_t busDataIn;
   logic     busAck;
   busWord_t busDataOut;

   step_t    steps[$];                        // Stimulus and expected response
   busWord_t modelMem [0:memWords-1];         // Reference main memory
   busWord_t modelHsb [0:31];                 // Reference HSB
   busWord_t modelMsr;
   integer   seed;
   int       checks;
   int       errors;
   int       waitCount;

   ks10Mem i_dut (
      .cpuClk     (cpuClk),
      .reset      (reset),
      .busReq     (busReq),
      .busAddrIn  (busAddrIn),
      .busDataIn  (busDataIn),
      .busAck     (busAck),
      .busDataOut (busDataOut)
   );

   initial
   begin
      cpuClk = 1'b0;
      forever #10 cpuClk = ~cpuClk;
   end

   initial
   begin
      reset = 1'b1;
      repeat (2) @(posedge cpuClk);
      @(negedge cpuClk);
      reset = 1'b0;                           // Released on a falling edge
   end

   ////////////////////////////////////////
   // Request words and reference model
   ////////////////////////////////////////

   function automatic busWord_t memWord(input logic rd, input logic wt, input logic wr,
                                        input logic [19:0] addr);
      busWord_t w;
      w = '0;
      w[flagRead]   = rd;
      w[flagWrTest] = wt;
      w[flagWrite]  = wr;
      w[flagPhys]   = 1'b1;
      w[memAddrFieldHi:memAddrFieldLo] = addr;
      return w;
   endfunction

   function automatic busWord_t ioWord(input logic rd, input logic wr, input devNum_t dev,
                                       input ioAddr_t ioAddr);
      busWord_t w;
      w = '0;
      w[flagRead]  = rd;
      w[flagWrite] = wr;
      w[flagPhys]  = 1'b1;
      w[flagIo]    = 1'b1;
      w[devFieldHi:devFieldLo]       = dev;
      w[ioAddrFieldHi:ioAddrFieldLo] = ioAddr;
      return w;
   endfunction

   task automatic modelStep(input logic req, input busWord_t a, input busWord_t d,
                            output logic ack, output busWord_t q);
      logic [19:0] ma;
      logic        impl;
      logic        inHsb;
      logic        isMsr;
      ack   = 1'b0;
      q     = '0;                             // Zero unless a read is acked
      ma    = a[memAddrFieldHi:memAddrFieldLo];
      impl  = (ma[19:memIndexWidth] == '0);
      inHsb = (ma[19:5] == hsbBase[16:30]);   // 32 word window
      isMsr = a[flagPhys] && (a[devFieldHi:devFieldLo] == memDevice) &&
              (a[ioAddrFieldHi:ioAddrFieldLo] == msrIoAddr);
      if (!req)
         ack = 1'b0;
      else if (a[flagIo])
      begin
         ack = isMsr && (a[flagRead] || a[flagWrite]);
         if (isMsr && a[flagRead])
            q = modelMsr;
         else if (isMsr && a[flagWrite])
            modelMsr = (modelMsr & ~msrWriteMask) | (d & msrWriteMask);
      end
      else if (a[flagRead])
      begin
         ack = inHsb || impl;                 // NXM read gets nothing
         if (inHsb)
            q = modelHsb[ma[4:0]];
         else if (impl)
            q = modelMem[ma[memIndexWidth-1:0]];
      end
      else if (a[flagWrite])
      begin
         ack = 1'b1;                          // Acked even when discarded
         if (inHsb)
            modelHsb[ma[4:0]] = d;
         else if (impl)
            modelMem[ma[memIndexWidth-1:0]] = d;
      end
      else
         ack = a[flagWrTest];                 // Write test only acks
   endtask

   task automatic addStep(input string name, input logic req, input busWord_t addr);
      step_t       s;
      logic [63:0] r;
      r      = {$random(seed), $random(seed)};
      s.name = name;
      s.req  = req;
      s.addr = addr;
      s.data = r[35:0];
      modelStep(req, addr, s.data, s.expAck, s.expData);
      steps.push_back(s);
   endtask

   task automatic checkResponse(input step_t s);
      checks++;
      assert (busAck === s.expAck)
      else
      begin
         errors++;
         $display("[ERROR] %s: ack expected %0b, actual %0b", s.name, s.expAck, busAck);
      end
      assert (busDataOut === s.expData)
      else
      begin
         errors++;
         $display("[ERROR] %s: data expected %012o, actual %012o", s.name, s.expData,
                  busDataOut);
      end
   endtask

   ////////////////////////////////////////
   // Stimulus table and main sequence
   ////////////////////////////////////////

   initial
   begin
      busReq    = 1'b0;
      busAddrIn = '0;
      busDataIn = '0;
      seed      = 32'hcbc8_f0c2;
      checks    = 0;
      errors    = 0;
      modelMsr  = msrResetValue;

      addStep("msr reset read", 1'b1, ioWord(1'b1, 1'b0, memDevice, msrIoAddr));
      addStep("mem write 5", 1'b1, memWord(1'b0, 1'b0, 1'b1, 20'd5));
      addStep("mem read 5 b2b", 1'b1, memWord(1'b1, 1'b0, 1'b0, 20'd5));
      addStep("mem write 1023", 1'b1, memWord(1'b0, 1'b0, 1'b1, 20'd1023));
      // Idle cycles carry a live address word, only the strobe is low
      addStep("idle 1", 1'b0, memWord(1'b1, 1'b0, 1'b0, 20'd1023));
      addStep("mem read 1023", 1'b1, memWord(1'b1, 1'b0, 1'b0, 20'd1023));
      addStep("hsb write 5", 1'b1, memWord(1'b0, 1'b0, 1'b1, 20'o376005));
      addStep("hsb read 5", 1'b1, memWord(1'b1, 1'b0, 1'b0, 20'o376005));
      addStep("mem 5 after hsb", 1'b1, memWord(1'b1, 1'b0, 1'b0, 20'd5));
      addStep("hsb write 37", 1'b1, memWord(1'b0, 1'b0, 1'b1, 20'o376037));
      addStep("hsb read 37", 1'b1, memWord(1'b1, 1'b0, 1'b0, 20'o376037));
      addStep("msr write", 1'b1, ioWord(1'b0, 1'b1, memDevice, msrIoAddr));
      addStep("msr merged read", 1'b1, ioWord(1'b1, 1'b0, memDevice, msrIoAddr));
      addStep("io wrong device", 1'b1, ioWord(1'b1, 1'b0, 4'd1, msrIoAddr));
      addStep("io wrong addr", 1'b1, ioWord(1'b1, 1'b0, memDevice, 18'o100001));
      addStep("nxm read", 1'b1, memWord(1'b1, 1'b0, 1'b0, 20'o2005));
      addStep("nxm write", 1'b1, memWord(1'b0, 1'b0, 1'b1, 20'o2005));
      addStep("mem 5 after nxm", 1'b1, memWord(1'b1, 1'b0, 1'b0, 20'd5));
      addStep("write test 5", 1'b1, memWord(1'b0, 1'b1, 1'b0, 20'd5));
      addStep("mem 5 after test", 1'b1, memWord(1'b1, 1'b0, 1'b0, 20'd5));
      addStep("idle 2", 1'b0, ioWord(1'b1, 1'b0, memDevice, msrIoAddr));
      // Back to back traffic, mixed targets
      addStep("pipe write 100", 1'b1, memWord(1'b0, 1'b0, 1'b1, 20'd100));
      addStep("pipe write 101", 1'b1, memWord(1'b0, 1'b0, 1'b1, 20'd101));
      addStep("pipe read 100", 1'b1, memWord(1'b1, 1'b0, 1'b0, 20'd100));
      addStep("pipe read 101", 1'b1, memWord(1'b1, 1'b0, 1'b0, 20'd101));
      addStep("pipe msr read", 1'b1, ioWord(1'b1, 1'b0, memDevice, msrIoAddr));
      addStep("pipe hsb read 5", 1'b1, memWord(1'b1, 1'b0, 1'b0, 20'o376005));
      addStep("pipe idle", 1'b0, memWord(1'b0, 1'b0, 1'b1, 20'd1023));
      addStep("pipe read 1023", 1'b1, memWord(1'b1, 1'b0, 1'b0, 20'd1023));

      waitCount = 0;
      while (reset !== 1'b0 && waitCount < 20)  // Reset release, bounded
      begin
         @(posedge cpuClk);
         waitCount++;
      end

      if (reset !== 1'b0)
      begin
         $display("Timed out waiting for reset to be released");
         $display("** FAIL **");
         $finish;
      end
      else
      begin
         for (int i = 0; i < steps.size(); i++)
         begin
            @(negedge cpuClk);
            if (i > 0)
               checkResponse(steps[i-1]);     // Response to the previous request
            busReq    = steps[i].req;
            busAddrIn = steps[i].addr;
            busDataIn = steps[i].data;
         end
         @(negedge cpuClk);
         checkResponse(steps[steps.size()-1]);
         busReq = 1'b0;

         $display("Checks: %0d, errors: %0d", checks, errors);
         if (errors == 0)
            $display("** PASS **");
         else
            $display("** FAIL **");
         $finish;
      end
   end

endmodule

// File: list.f
verilog/ks10MemPkg.sv
verilog/memBusIf.sv
verilog/memDecode.sv
verilog/memStat.sv
verilog/memArray.sv
verilog/memResponse.sv
verilog/ks10Mem.sv
bench/ks10MemTb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = ks10MemTb
FILELIST  = list.f
OBJDIR    = obj_dir
PASS_MSG  = ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# Status comes from grep, so a missing pass line fails the target
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
